//--- src/commit_consts.svh
`ifndef COMMIT_CONSTS_SVH
`define COMMIT_CONSTS_SVH

// data and address width
`define WORD_SIZE 16

// write-back and cdb ports
`define NUM_FU 2

`define NUM_PHYS_REG 32

// reorder buffer depth as a power of two
`define ROB_ENTRY 8

// store buffer depth as a power of two
`define SB_ENTRY 4

`endif

//--- src/commit_pkg.sv
`include "commit_consts.svh"

package commit_pkg;

  // data or address word
  typedef logic [`WORD_SIZE-1:0] word_t;

  // physical register number
  typedef logic [$clog2(`NUM_PHYS_REG)-1:0] preg_t;

  // reorder buffer slot
  typedef logic [$clog2(`ROB_ENTRY)-1:0] rob_idx_t;

  // store buffer slot
  typedef logic [$clog2(`SB_ENTRY)-1:0] sb_idx_t;

endpackage

//--- src/rob_commit_if.sv
`timescale 1ns/1ps

// one retirement event per cycle consumed at the same edge
interface rob_commit_if;
  logic              commit_v;
  logic              has_dest;
  commit_pkg::preg_t free_preg;
  logic              is_store;
  logic              mispredict;

  modport rob (
    output commit_v, has_dest, free_preg, is_store, mispredict
  );

  // register file only cares about freed registers
  modport rf_sink (
    input commit_v, has_dest, free_preg
  );

  modport sb_sink (
    input commit_v, is_store, mispredict
  );
endinterface

//--- src/rob.sv
`timescale 1ns/1ps
`include "commit_consts.svh"

module rob
(input  logic                   clk_i
 , input  logic                 reset_i
 // rename side
 , input  logic                 rename_rob_valid_i
 , input  logic                 rename_has_dest_i
 , input  commit_pkg::preg_t    rename_old_preg_i
 , input  logic                 rename_is_store_i
 , output logic                 rob_rename_ready_o
 , output commit_pkg::rob_idx_t rob_rename_entry_num_o
 // cdb completions
 , input  logic [`NUM_FU-1:0]   cdb_v_i
 , input  commit_pkg::rob_idx_t cdb_rob_num_i [`NUM_FU]
 , input  logic [`NUM_FU-1:0]   cdb_mispredict_i
 , input  commit_pkg::word_t    cdb_target_i [`NUM_FU]
 // retirement
 , output logic                 rob_rename_valid_o
 , output commit_pkg::preg_t    rob_rename_free_preg_o
 , output logic                 rob_mispredict_o
 , output commit_pkg::word_t    rob_fe_redirected_pc_o
 , rob_commit_if.rob            commit_o
);
  import commit_pkg::*;

  localparam int unsigned cnt_w = $clog2(`ROB_ENTRY) + 1;

  logic                  has_dest_q [`ROB_ENTRY];
  preg_t                 old_preg_q [`ROB_ENTRY];
  logic                  is_store_q [`ROB_ENTRY];
  logic                  mispredict_q [`ROB_ENTRY];
  word_t                 target_q [`ROB_ENTRY];
  logic [`ROB_ENTRY-1:0] done_q;

  rob_idx_t         head_q;
  rob_idx_t         tail_q;
  logic [cnt_w-1:0] count_q;

  logic alloc;
  logic retire;
  logic flush;

  assign rob_rename_ready_o     = (count_q != cnt_w'(`ROB_ENTRY));
  assign rob_rename_entry_num_o = tail_q;

  assign alloc  = rename_rob_valid_i && rob_rename_ready_o;
  // head retires as soon as it is done
  assign retire = (count_q != '0) && done_q[head_q];
  assign flush  = retire && mispredict_q[head_q];

  assign rob_rename_valid_o     = retire;
  assign rob_rename_free_preg_o = old_preg_q[head_q];
  assign rob_mispredict_o       = flush;
  assign rob_fe_redirected_pc_o = target_q[head_q];

  assign commit_o.commit_v   = retire;
  assign commit_o.has_dest   = has_dest_q[head_q];
  assign commit_o.free_preg  = old_preg_q[head_q];
  assign commit_o.is_store   = is_store_q[head_q];
  assign commit_o.mispredict = flush;

  // entry payload
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      has_dest_q[tail_q] <= rename_has_dest_i;
      old_preg_q[tail_q] <= rename_old_preg_i;
      is_store_q[tail_q] <= rename_is_store_i;
    end
    for (int k = 0; k < `NUM_FU; k++) begin
      if (cdb_v_i[k]) begin
        mispredict_q[cdb_rob_num_i[k]] <= cdb_mispredict_i[k];
        target_q[cdb_rob_num_i[k]]     <= cdb_target_i[k];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc) begin
        done_q[tail_q] <= 1'b0;
      end
      // completions may arrive in any order
      for (int k = 0; k < `NUM_FU; k++) begin
        if (cdb_v_i[k]) begin
          done_q[cdb_rob_num_i[k]] <= 1'b1;
        end
      end
      if (flush) begin
        // everything younger than the branch is gone
        head_q  <= head_q + 1'b1;
        tail_q  <= head_q + 1'b1;
        count_q <= '0;
      end else begin
        if (retire) begin
          head_q <= head_q + 1'b1;
        end
        if (alloc) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + cnt_w'(alloc) - cnt_w'(retire);
      end
    end
  end

endmodule

//--- src/arch_state.sv
`timescale 1ns/1ps
`include "commit_consts.svh"

module arch_state
(input  logic                 clk_i
 , input  logic               reset_i
 // write-back from execute
 , input  logic [`NUM_FU-1:0] exe_w_v_i
 , input  commit_pkg::preg_t  exe_addr_i [`NUM_FU]
 , input  commit_pkg::word_t  exe_data_i [`NUM_FU]
 // issue read ports
 , input  commit_pkg::preg_t  issue_read_rs1_i
 , output logic               rs1_valid_o
 , output commit_pkg::word_t  rs1_data_o
 , input  commit_pkg::preg_t  issue_read_rs2_i
 , output logic               rs2_valid_o
 , output commit_pkg::word_t  rs2_data_o
 , rob_commit_if.rf_sink      commit_i
);
  import commit_pkg::*;

  word_t                    regs_q [`NUM_PHYS_REG];
  logic [`NUM_PHYS_REG-1:0] valid_q;

  // register values
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < `NUM_FU; k++) begin
      if (exe_w_v_i[k]) begin
        regs_q[exe_addr_i[k]] <= exe_data_i[k];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      // freed register holds a stale value
      if (commit_i.commit_v && commit_i.has_dest) begin
        valid_q[commit_i.free_preg] <= 1'b0;
      end
      // a write to the same register wins over the free
      for (int k = 0; k < `NUM_FU; k++) begin
        if (exe_w_v_i[k]) begin
          valid_q[exe_addr_i[k]] <= 1'b1;
        end
      end
    end
  end

  assign rs1_valid_o = valid_q[issue_read_rs1_i];
  assign rs1_data_o  = regs_q[issue_read_rs1_i];
  assign rs2_valid_o = valid_q[issue_read_rs2_i];
  assign rs2_data_o  = regs_q[issue_read_rs2_i];

endmodule

//--- src/store_buffer.sv
`timescale 1ns/1ps
`include "commit_consts.svh"

module store_buffer
(input  logic                  clk_i
 , input  logic                reset_i
 // allocation at issue
 , input  logic                issue_sb_v_i
 , output logic                sb_issue_ready_o
 , output commit_pkg::sb_idx_t sb_issue_entry_num_o
 // fill from execute
 , input  logic                exe_sb_v_i
 , input  commit_pkg::sb_idx_t exe_sb_num_i
 , input  commit_pkg::word_t   exe_sb_addr_i
 , input  commit_pkg::word_t   exe_sb_data_i
 // load bypass
 , input  commit_pkg::word_t   exe_ld_bypass_addr_i
 , input  commit_pkg::sb_idx_t exe_ld_bypass_sb_num_i
 , output logic                sb_ld_bypass_valid_o
 , output commit_pkg::word_t   sb_ld_bypass_value_o
 // drain to memory
 , output logic                data_mem_w_v_o
 , output commit_pkg::word_t   data_mem_w_addr_o
 , output commit_pkg::word_t   data_mem_w_data_o
 , rob_commit_if.sb_sink       commit_i
);
  import commit_pkg::*;

  localparam int unsigned cnt_w = $clog2(`SB_ENTRY) + 1;

  logic [`SB_ENTRY-1:0] filled_q;
  logic [`SB_ENTRY-1:0] committed_q;
  word_t                addr_q [`SB_ENTRY];
  word_t                data_q [`SB_ENTRY];

  sb_idx_t drain_q;
  sb_idx_t commit_q;
  sb_idx_t tail_q;
  // live entries, and committed ones not yet drained
  logic [cnt_w-1:0] cnt_q;
  logic [cnt_w-1:0] ccnt_q;
  logic [cnt_w-1:0] ccnt_next;

  logic alloc;
  logic commit_st;
  logic flush;
  logic drain_v;

  assign sb_issue_ready_o     = (cnt_q != cnt_w'(`SB_ENTRY));
  assign sb_issue_entry_num_o = tail_q;

  assign alloc     = issue_sb_v_i && sb_issue_ready_o;
  assign commit_st = commit_i.commit_v && commit_i.is_store;
  assign flush     = commit_i.commit_v && commit_i.mispredict;
  assign drain_v   = committed_q[drain_q] && filled_q[drain_q];
  assign ccnt_next = ccnt_q + cnt_w'(commit_st) - cnt_w'(drain_v);

  // oldest committed store goes out first
  assign data_mem_w_v_o    = drain_v;
  assign data_mem_w_addr_o = addr_q[drain_q];
  assign data_mem_w_data_o = data_q[drain_q];

  always_ff @(posedge clk_i) begin
    if (exe_sb_v_i) begin
      addr_q[exe_sb_num_i] <= exe_sb_addr_i;
      data_q[exe_sb_num_i] <= exe_sb_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      filled_q    <= '0;
      committed_q <= '0;
      drain_q     <= '0;
      commit_q    <= '0;
      tail_q      <= '0;
      cnt_q       <= '0;
      ccnt_q      <= '0;
    end else begin
      if (alloc) begin
        filled_q[tail_q]    <= 1'b0;
        committed_q[tail_q] <= 1'b0;
      end
      if (exe_sb_v_i) begin
        filled_q[exe_sb_num_i] <= 1'b1;
      end
      if (commit_st) begin
        committed_q[commit_q] <= 1'b1;
        commit_q              <= commit_q + 1'b1;
      end
      if (drain_v) begin
        filled_q[drain_q]    <= 1'b0;
        committed_q[drain_q] <= 1'b0;
        drain_q              <= drain_q + 1'b1;
      end
      ccnt_q <= ccnt_next;
      if (flush) begin
        // only committed stores survive a mispredict
        tail_q <= commit_q + sb_idx_t'(commit_st);
        cnt_q  <= ccnt_next;
      end else begin
        if (alloc) begin
          tail_q <= tail_q + 1'b1;
        end
        cnt_q <= cnt_q + cnt_w'(alloc) - cnt_w'(drain_v);
      end
    end
  end

  // youngest older store with a matching address
  always_comb begin
    sb_idx_t idx;
    sb_idx_t age;
    idx                  = '0;
    age                  = exe_ld_bypass_sb_num_i - drain_q;
    sb_ld_bypass_valid_o = 1'b0;
    sb_ld_bypass_value_o = '0;
    for (int i = 1; i < `SB_ENTRY; i++) begin
      idx = exe_ld_bypass_sb_num_i - sb_idx_t'(i);
      if (!sb_ld_bypass_valid_o && (i <= int'(age)) && filled_q[idx]
          && (addr_q[idx] == exe_ld_bypass_addr_i)) begin
        sb_ld_bypass_valid_o = 1'b1;
        sb_ld_bypass_value_o = data_q[idx];
      end
    end
  end

endmodule

//--- src/commit_stage.sv
`timescale 1ns/1ps
`include "commit_consts.svh"

module commit_stage
(input  logic                   clk_i
 , input  logic                 reset_i
 // execute register write-back
 , input  logic [`NUM_FU-1:0]   exe_w_v_i
 , input  commit_pkg::preg_t    exe_addr_i [`NUM_FU]
 , input  commit_pkg::word_t    exe_data_i [`NUM_FU]
 // issue read ports
 , input  commit_pkg::preg_t    issue_read_rs1_i
 , input  commit_pkg::preg_t    issue_read_rs2_i
 , output logic                 rs1_valid_o
 , output logic                 rs2_valid_o
 , output commit_pkg::word_t    rs1_data_o
 , output commit_pkg::word_t    rs2_data_o
 // rename to rob
 , input  logic                 rename_rob_valid_i
 , input  logic                 rename_has_dest_i
 , input  commit_pkg::preg_t    rename_old_preg_i
 , input  logic                 rename_is_store_i
 , output logic                 rob_rename_ready_o
 , output commit_pkg::rob_idx_t rob_rename_entry_num_o
 // cdb to rob
 , input  logic [`NUM_FU-1:0]   cdb_v_i
 , input  commit_pkg::rob_idx_t cdb_rob_num_i [`NUM_FU]
 , input  logic [`NUM_FU-1:0]   cdb_mispredict_i
 , input  commit_pkg::word_t    cdb_target_i [`NUM_FU]
 // retirement back to rename and fetch
 , output logic                 rob_rename_valid_o
 , output commit_pkg::preg_t    rob_rename_free_preg_o
 , output logic                 rob_mispredict_o
 , output commit_pkg::word_t    rob_fe_redirected_pc_o
 // store allocation and fill
 , input  logic                 issue_sb_v_i
 , output logic                 sb_issue_ready_o
 , output commit_pkg::sb_idx_t  sb_issue_entry_num_o
 , input  logic                 exe_sb_v_i
 , input  commit_pkg::sb_idx_t  exe_sb_num_i
 , input  commit_pkg::word_t    exe_sb_addr_i
 , input  commit_pkg::word_t    exe_sb_data_i
 // load bypass
 , input  commit_pkg::word_t    exe_ld_bypass_addr_i
 , input  commit_pkg::sb_idx_t  exe_ld_bypass_sb_num_i
 , output logic                 sb_ld_bypass_valid_o
 , output commit_pkg::word_t    sb_ld_bypass_value_o
 // data memory
 , input  commit_pkg::word_t    exe_mem_addr_i
 , output commit_pkg::word_t    exe_mem_data_o
 , output logic                 data_mem_w_v_o
 , output commit_pkg::word_t    data_mem_w_addr_o
 , output commit_pkg::word_t    data_mem_w_data_o
 , output commit_pkg::word_t    data_mem_r_addr_o
 , input  commit_pkg::word_t    data_mem_r_data_i
);

  // retirement events out of the rob
  rob_commit_if commit_if ();

  rob reorder_buffer
  (  .commit_o (commit_if)
   , .*
  );

  arch_state states
  (  .commit_i (commit_if)
   , .*
  );

  store_buffer sb
  (  .commit_i (commit_if)
   , .*
  );

  // memory read path is combinational
  assign data_mem_r_addr_o = exe_mem_addr_i;
  assign exe_mem_data_o    = data_mem_r_data_i;

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(output logic clk_o
 , output logic reset_o
);
  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held over two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end
endmodule

//--- testbench/commit_stage_sva.sv
`timescale 1ns/1ps

module commit_stage_sva
(input  logic clk_i
 , input logic reset_i
 , input logic rename_rob_valid_i
 , input logic rob_rename_ready_o
 , input logic issue_sb_v_i
 , input logic sb_issue_ready_o
 , input logic rob_rename_valid_o
 , input logic rob_mispredict_o
 , input logic data_mem_w_v_o
);
  rename_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    rename_rob_valid_i |-> rob_rename_ready_o)
    else $error("rename while the reorder buffer is full");

  alloc_when_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_sb_v_i |-> sb_issue_ready_o)
    else $error("store allocation while the store buffer is full");

  // the rob is empty after a redirect
  no_retire_after_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    rob_mispredict_o |=> !rob_rename_valid_o)
    else $error("retirement right after a mispredict");

  no_write_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |-> !data_mem_w_v_o)
    else $error("memory write during reset");
endmodule

bind commit_stage commit_stage_sva i_commit_stage_sva (.*);

//--- testbench/commit_stage_tb.sv
`timescale 1ns/1ps
`include "commit_consts.svh"

module commit_stage_tb;
  import commit_pkg::*;

  localparam int op_rename   = 0;
  localparam int op_wb       = 1;
  localparam int op_complete = 2;
  localparam int op_issue    = 3;
  localparam int op_fill     = 4;
  localparam int op_bypass   = 5;
  localparam int op_read     = 6;
  localparam int op_ready    = 7;
  localparam int op_wait     = 8;
  localparam int op_idle     = 9;
  localparam int op_mem      = 10;

  typedef struct {
    int t;
    int op;
    int a;
    int b;
    int c;
  } row_t;

  logic clk_i;
  logic reset_i;
  logic [`NUM_FU-1:0] exe_w_v_i, cdb_v_i, cdb_mispredict_i;
  preg_t exe_addr_i [`NUM_FU];
  word_t exe_data_i [`NUM_FU];
  word_t cdb_target_i [`NUM_FU];
  rob_idx_t cdb_rob_num_i [`NUM_FU];
  preg_t issue_read_rs1_i, issue_read_rs2_i, rename_old_preg_i, rob_rename_free_preg_o;
  logic rs1_valid_o, rs2_valid_o, rename_rob_valid_i, rename_has_dest_i, rename_is_store_i;
  logic rob_rename_ready_o, rob_rename_valid_o, rob_mispredict_o, issue_sb_v_i;
  logic sb_issue_ready_o, exe_sb_v_i, sb_ld_bypass_valid_o, data_mem_w_v_o;
  word_t rs1_data_o, rs2_data_o, rob_fe_redirected_pc_o, exe_sb_addr_i, exe_sb_data_i;
  word_t exe_ld_bypass_addr_i, sb_ld_bypass_value_o, exe_mem_addr_i, exe_mem_data_o;
  word_t data_mem_w_addr_o, data_mem_w_data_o, data_mem_r_addr_o, data_mem_r_data_i;
  rob_idx_t rob_rename_entry_num_o;
  sb_idx_t sb_issue_entry_num_o, exe_sb_num_i, exe_ld_bypass_sb_num_i;

  // reference model of rob entries, stores and registers
  row_t rows[$];
  int robq[$];
  int sbq[$];
  int r_slot [16], r_old [16], s_slot [16];
  bit r_dest [16], r_store [16], r_done [16], r_mis [16], s_filled [16];
  logic [15:0] r_tgt [16], s_addr [16], s_data [16], rd [32];
  bit rv [32];
  int nren, nst, ncommit, rob_tail, sb_tail;
  int errors, checks, test_errs;
  logic [15:0] lfsr_q, addr_base;

  tb_clock clock_gen (.clk_o(clk_i), .reset_o(reset_i));

  commit_stage i_commit_stage (.*);

  // galois lfsr stepped once per bit taken
  function automatic logic [15:0] next_random(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic void add_row(input int t, input int op, input int a = 0,
                                  input int b = 0, input int c = 0);
    row_t r;
    r = '{t, op, a, b, c};
    rows.push_back(r);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic clear_strobes();
    exe_w_v_i          = '0;
    cdb_v_i            = '0;
    cdb_mispredict_i   = '0;
    rename_rob_valid_i = 1'b0;
    issue_sb_v_i       = 1'b0;
    exe_sb_v_i         = 1'b0;
  endtask

  // sampled at the falling edge before new inputs
  task automatic observe();
    int s;
    if (data_mem_w_v_o) begin
      if (ncommit == 0) begin
        report_error("memory write without a retired store");
      end else begin
        s = sbq.pop_front();
        ncommit--;
        check_val("data_mem_w_addr_o", data_mem_w_addr_o, s_addr[s]);
        check_val("data_mem_w_data_o", data_mem_w_data_o, s_data[s]);
      end
    end
    if (rob_rename_valid_o) begin
      if (robq.size() == 0 || !r_done[robq[0]]) begin
        report_error("retirement before the oldest entry completed");
      end else begin
        s = robq.pop_front();
        check_val("rob_rename_free_preg_o", rob_rename_free_preg_o, r_old[s]);
        check_val("rob_mispredict_o", rob_mispredict_o, r_mis[s]);
        if (r_dest[s]) rv[r_old[s]] = 1'b0;
        if (r_store[s]) ncommit++;
        if (r_mis[s]) begin
          check_val("rob_fe_redirected_pc_o", rob_fe_redirected_pc_o, r_tgt[s]);
          // younger entries and uncommitted stores are dropped
          rob_tail = (r_slot[s] + 1) % `ROB_ENTRY;
          robq.delete();
          if (sbq.size() > ncommit) sb_tail = s_slot[sbq[ncommit]];
          while (sbq.size() > ncommit) void'(sbq.pop_back());
        end
      end
    end else if (robq.size() != 0 && r_done[robq[0]]) begin
      report_error("oldest entry completed but did not retire");
    end
  endtask

  task automatic apply(input row_t r);
    logic [15:0] d;
    logic ev;
    logic [15:0] ed;
    int p;
    d = next_random(16);
    p = r.a % `NUM_FU;
    case (r.op)
      op_rename: begin
        check_val("rob_rename_ready_o", rob_rename_ready_o, 1);
        check_val("rob_rename_entry_num_o", rob_rename_entry_num_o, rob_tail);
        rename_rob_valid_i = 1'b1;
        rename_has_dest_i  = r.a[0];
        rename_old_preg_i  = preg_t'(r.b);
        rename_is_store_i  = r.c[0];
        r_slot[nren]  = rob_tail;
        r_dest[nren]  = r.a[0];
        r_old[nren]   = r.b;
        r_store[nren] = r.c[0];
        r_done[nren]  = 1'b0;
        robq.push_back(nren);
        nren++;
        rob_tail = (rob_tail + 1) % `ROB_ENTRY;
      end
      op_wb: begin
        exe_w_v_i[0]  = 1'b1;
        exe_addr_i[0] = preg_t'(r.a);
        exe_data_i[0] = d;
        rv[r.a] = 1'b1;
        rd[r.a] = d;
      end
      op_complete: begin
        cdb_v_i[p]          = 1'b1;
        cdb_rob_num_i[p]    = rob_idx_t'(r_slot[r.a]);
        cdb_mispredict_i[p] = r.b[0];
        cdb_target_i[p]     = d;
        r_done[r.a] = 1'b1;
        r_mis[r.a]  = r.b[0];
        r_tgt[r.a]  = d;
      end
      op_issue: begin
        check_val("sb_issue_ready_o", sb_issue_ready_o, 1);
        check_val("sb_issue_entry_num_o", sb_issue_entry_num_o, sb_tail);
        issue_sb_v_i = 1'b1;
        s_slot[nst]   = sb_tail;
        s_filled[nst] = 1'b0;
        sbq.push_back(nst);
        nst++;
        sb_tail = (sb_tail + 1) % `SB_ENTRY;
      end
      op_fill: begin
        exe_sb_v_i    = 1'b1;
        exe_sb_num_i  = sb_idx_t'(s_slot[r.a]);
        exe_sb_addr_i = addr_base + 16'(r.b);
        exe_sb_data_i = d;
        s_addr[r.a]   = addr_base + 16'(r.b);
        s_data[r.a]   = d;
        s_filled[r.a] = 1'b1;
      end
      op_bypass: begin
        exe_ld_bypass_addr_i   = addr_base + 16'(r.b);
        exe_ld_bypass_sb_num_i = sb_idx_t'(s_slot[r.a]);
        #1;
        ev = 1'b0;
        ed = '0;
        // later matches in program order are younger
        for (int k = 0; k < sbq.size() && sbq[k] != r.a; k++) begin
          if (s_filled[sbq[k]] && s_addr[sbq[k]] == exe_ld_bypass_addr_i) begin
            ev = 1'b1;
            ed = s_data[sbq[k]];
          end
        end
        check_val("sb_ld_bypass_valid_o", sb_ld_bypass_valid_o, ev);
        if (ev) check_val("sb_ld_bypass_value_o", sb_ld_bypass_value_o, ed);
      end
      op_read: begin
        issue_read_rs1_i = preg_t'(r.a);
        issue_read_rs2_i = preg_t'(r.b);
        #1;
        check_val("rs1_valid_o", rs1_valid_o, rv[r.a]);
        if (rv[r.a]) check_val("rs1_data_o", rs1_data_o, rd[r.a]);
        check_val("rs2_valid_o", rs2_valid_o, rv[r.b]);
        if (rv[r.b]) check_val("rs2_data_o", rs2_data_o, rd[r.b]);
      end
      op_ready: begin
        check_val("rob_rename_ready_o", rob_rename_ready_o, 1);
        check_val("sb_issue_ready_o", sb_issue_ready_o, 1);
      end
      op_mem: begin
        ed = next_random(16);
        exe_mem_addr_i    = d;
        data_mem_r_data_i = ed;
        #1;
        check_val("data_mem_r_addr_o", data_mem_r_addr_o, d);
        check_val("exe_mem_data_o", exe_mem_data_o, ed);
      end
      op_wait: begin
        for (int k = 0; k < 50 && (robq.size() != 0 || ncommit != 0); k++) begin
          @(negedge clk_i);
          observe();
        end
        if (robq.size() != 0 || ncommit != 0) report_error("timeout waiting for retirement");
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    lfsr_q = 16'd52;
    errors = 0;
    checks = 0;
    test_errs = 0;
    nren = 0;
    nst = 0;
    ncommit = 0;
    rob_tail = 0;
    sb_tail = 0;
    foreach (rv[i]) rv[i] = 1'b0;
    clear_strobes();
    for (int k = 0; k < `NUM_FU; k++) begin
      exe_addr_i[k]    = '0;
      exe_data_i[k]    = '0;
      cdb_rob_num_i[k] = '0;
      cdb_target_i[k]  = '0;
    end
    issue_read_rs1_i = '0;
    issue_read_rs2_i = '0;
    rename_has_dest_i = 1'b0;
    rename_old_preg_i = '0;
    rename_is_store_i = 1'b0;
    exe_sb_num_i = '0;
    exe_sb_addr_i = '0;
    exe_sb_data_i = '0;
    exe_ld_bypass_addr_i = '0;
    exe_ld_bypass_sb_num_i = '0;
    exe_mem_addr_i = '0;
    data_mem_r_data_i = '0;
    addr_base = next_random(16);

    add_row(1, op_ready);
    add_row(1, op_read, 5, 6);
    add_row(1, op_mem);
    add_row(2, op_wb, 5);
    add_row(2, op_read, 5, 3);
    add_row(2, op_read, 3, 5);
    add_row(2, op_rename, 1, 5, 0);
    add_row(2, op_complete, 0);
    add_row(2, op_wait);
    add_row(2, op_read, 5, 3);
    // completions arrive youngest first
    add_row(3, op_rename, 1, 7, 0);
    add_row(3, op_rename, 1, 8, 0);
    add_row(3, op_rename, 1, 9, 0);
    add_row(3, op_complete, 3);
    add_row(3, op_complete, 2);
    add_row(3, op_idle);
    add_row(3, op_idle);
    add_row(3, op_complete, 1);
    add_row(3, op_wait);
    add_row(4, op_issue);
    add_row(4, op_issue);
    add_row(4, op_fill, 0, 3);
    add_row(4, op_fill, 1, 4);
    add_row(4, op_rename, 0, 0, 1);
    add_row(4, op_rename, 0, 0, 1);
    add_row(4, op_complete, 5);
    add_row(4, op_complete, 4);
    add_row(4, op_wait);
    // two stores share an address and none retires
    add_row(5, op_issue);
    add_row(5, op_issue);
    add_row(5, op_issue);
    add_row(5, op_fill, 2, 0);
    add_row(5, op_fill, 3, 0);
    add_row(5, op_fill, 4, 1);
    add_row(5, op_bypass, 4, 0);
    add_row(5, op_bypass, 4, 2);
    add_row(5, op_bypass, 3, 0);
    add_row(6, op_rename, 0, 0, 0);
    add_row(6, op_rename, 1, 10, 0);
    add_row(6, op_rename, 0, 0, 1);
    add_row(6, op_issue);
    add_row(6, op_fill, 5, 0);
    add_row(6, op_complete, 7);
    add_row(6, op_complete, 8);
    add_row(6, op_complete, 6, 1);
    add_row(6, op_wait);
    add_row(6, op_ready);
    add_row(6, op_idle);
    add_row(6, op_idle);
    add_row(6, op_idle);

    for (int k = 0; k < 20 && reset_i !== 1'b0; k++) @(negedge clk_i);
    if (reset_i !== 1'b0) report_error("reset never released");

    foreach (rows[i]) begin
      @(negedge clk_i);
      observe();
      clear_strobes();
      apply(rows[i]);
      if (i == rows.size() - 1 || rows[i + 1].t != rows[i].t) begin
        $display("test %0d: %s", rows[i].t, (errors == test_errs) ? "ok" : "failed");
        test_errs = errors;
      end
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end
endmodule

//--- commit_stage.f
+incdir+src
src/commit_pkg.sv
src/rob_commit_if.sv
src/rob.sv
src/arch_state.sv
src/store_buffer.sv
src/commit_stage.sv
testbench/tb_clock.sv
testbench/commit_stage_sva.sv
testbench/commit_stage_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f commit_stage.f \
	  --top-module commit_stage_tb -o commit_stage_tb

run: compile
	./obj_dir/commit_stage_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  test $$status -eq 0 && ! grep -q "Done: errors found" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
